/* src.f */
+incdir+design
design/stamofu_pkg.sv
design/stamofu_issue_steer.sv
design/stamofu_addr_lane.sv
design/stamofu_req_arb.sv
design/stamofu_addr_top.sv
verif/stamofu_clk_gen.sv
verif/stamofu_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the store address unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

obj_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f src.f --top-module stamofu_tb \
    -Mdir "$obj_dir" -o stamofu_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

"./$obj_dir/stamofu_sim" > "$log_file" 2>&1
status=$?
cat "$log_file"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "Test OK" "$log_file"; then
    exit 0
else
    echo "pass message not found in $log_file"
    exit 1
fi

/* verif/stamofu_tb.sv */
// store address unit testbench

`timescale 1ns/10ps
`default_nettype none

`include "stamofu_consts.svh"

module stamofu_tb;

    import stamofu_pkg::*;

    localparam int num_ops = 82;
    localparam int reset_cycles = 8;
    localparam int cycle_limit = 40 * num_ops + reset_cycles;
    localparam int num_idx = 1 << `CQ_INDEX_WIDTH;

    logic           CLK;
    logic           nRST;
    logic           issue_valid;
    stamofu_issue_t issue;
    logic           issue_ready;
    logic           req_valid;
    stamofu_req_t   req;
    logic           req_ack;

    // expected beats per completion-queue index
    stamofu_req_t exp_beat [num_idx][2];
    int           exp_head [num_idx];
    int           exp_left [num_idx];

    logic [15:0]  stim_lfsr;
    logic [15:0]  ack_lfsr;
    logic         ack_random;
    logic         held_valid;
    stamofu_req_t held_req;
    logic         mq_due;
    logic [`CQ_INDEX_WIDTH-1:0] mq_idx;
    int           err_count;
    int           pass_count;
    int           fail_count;
    int           cycles = 0;

    stamofu_clk_gen #(
        .half_period(50),
        .reset_cycles(reset_cycles)
    ) clk_gen_i (
        .CLK(CLK),
        .nRST(nRST)
    );

    stamofu_addr_top stamofu_addr_top_i (
        .CLK(CLK),
        .nRST(nRST),
        .issue_valid(issue_valid),
        .issue(issue),
        .issue_ready(issue_ready),
        .req_valid(req_valid),
        .req(req),
        .req_ack(req_ack)
    );

    // ------------------------------------------------------------
    // random source and reference model
    // ------------------------------------------------------------

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        logic [15:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 16'hB400;
        end
        return n;
    endfunction

    task automatic rand_bits(inout logic [15:0] st, input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            st = lfsr_step(st);
            v = {v[30:0], st[0]};
        end
    endtask

    // returns how many of b0 and b1 are expected
    function automatic int ref_beats(input stamofu_issue_t op, output stamofu_req_t b0,
                                     output stamofu_req_t b1);
        logic [31:0] va;
        logic [31:0] va_next;
        logic [1:0]  off;
        logic [7:0]  span;
        logic [63:0] twice;
        if (op.kind == KIND_AMO) begin
            va = op.base;
        end else begin
            va = op.base + 32'($signed(op.imm12));
        end
        va_next = va + 32'd4;
        off = va[1:0];
        // upper nibble of the byte span spills into the next word
        span = 8'b0000_1111;
        if (op.kind == KIND_STORE && op.size == SIZE_B) begin
            span = 8'b0000_0001;
        end else if (op.kind == KIND_STORE && op.size == SIZE_H) begin
            span = 8'b0000_0011;
        end
        span = span << off;
        twice = {op.data, op.data} << (8 * off);
        b0.kind = op.kind;
        b0.size = op.size;
        b0.amo_op = op.amo_op;
        b0.is_mq = 1'b0;
        b0.misaligned = (op.kind == KIND_STORE) && (span[7:4] != 4'b0000);
        b0.misaligned_exception = (op.kind == KIND_AMO) && (off != 2'd0);
        b0.vpn = va[31:12];
        b0.po_word = va[11:2];
        b0.byte_mask = span[3:0];
        b0.write_data = twice[63:32];
        b0.cq_index = op.cq_index;
        b1 = b0;
        b1.is_mq = 1'b1;
        b1.vpn = va_next[31:12];
        b1.po_word = va_next[11:2];
        b1.byte_mask = span[7:4];
        return b0.misaligned ? 2 : 1;
    endfunction

    // ------------------------------------------------------------
    // compare tasks
    // ------------------------------------------------------------

    task automatic check_field(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        if (exp !== act) begin
            $display("Error: time %0t, req.%s expected %h, actual %h", $time, name, exp, act);
            err_count++;
        end
    endtask

    task automatic compare_req(input stamofu_req_t exp, input stamofu_req_t act);
        check_field("kind", 32'(exp.kind), 32'(act.kind));
        check_field("size", 32'(exp.size), 32'(act.size));
        check_field("amo_op", 32'(exp.amo_op), 32'(act.amo_op));
        check_field("is_mq", 32'(exp.is_mq), 32'(act.is_mq));
        check_field("misaligned", 32'(exp.misaligned), 32'(act.misaligned));
        check_field("misaligned_exception", 32'(exp.misaligned_exception),
                    32'(act.misaligned_exception));
        check_field("vpn", 32'(exp.vpn), 32'(act.vpn));
        check_field("po_word", 32'(exp.po_word), 32'(act.po_word));
        check_field("byte_mask", 32'(exp.byte_mask), 32'(act.byte_mask));
        check_field("write_data", exp.write_data, act.write_data);
        check_field("cq_index", 32'(exp.cq_index), 32'(act.cq_index));
    endtask

    task automatic compare_bit(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("Error: time %0t, %s expected %b, actual %b", $time, name, exp, act);
            err_count++;
        end
    endtask

    // ------------------------------------------------------------
    // monitor, ack driver and watchdog
    // ------------------------------------------------------------

    // a beat seen acked at the falling edge completes at the next rise
    always @(negedge CLK) begin : monitor
        int idx;
        if (!nRST) begin
            held_valid = 1'b0;
            mq_due = 1'b0;
        end else begin
            if (held_valid && (!req_valid || req !== held_req)) begin
                $display("Error: time %0t, req changed while held, expected %h, actual %h",
                         $time, held_req, req);
                err_count++;
            end
            held_valid = req_valid && !req_ack;
            held_req = req;
            if (req_valid && req_ack) begin
                idx = int'(req.cq_index);
                if (mq_due && !(req.is_mq && req.cq_index == mq_idx)) begin
                    $display("second beat for cq_index %0d did not follow its first beat",
                             mq_idx);
                    err_count++;
                end
                if (exp_left[idx] == 0) begin
                    $display("beat for cq_index %0d arrived with no beat expected", idx);
                    err_count++;
                    mq_due = 1'b0;
                end else begin
                    compare_req(exp_beat[idx][exp_head[idx]], req);
                    exp_head[idx]++;
                    exp_left[idx]--;
                    mq_due = (exp_left[idx] != 0);
                    mq_idx = req.cq_index;
                end
            end
        end
    end

    always @(posedge CLK) begin : ack_drive
        logic [31:0] v;
        #10;
        if (!nRST) begin
            req_ack = 1'b0;
        end else if (ack_random) begin
            rand_bits(ack_lfsr, 2, v);
            req_ack = (v[1:0] != 2'b00);
        end else begin
            req_ack = 1'b1;
        end
    end

    always @(posedge CLK) begin : watchdog
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("timeout after %0d cycles, requests stopped draining", cycles);
            $display("Test FAILED");
            $finish;
        end
    end

    // ------------------------------------------------------------
    // stimulus tasks
    // ------------------------------------------------------------

    task automatic pick_index(input logic [`CQ_INDEX_WIDTH-1:0] start,
                              output logic [`CQ_INDEX_WIDTH-1:0] idx);
        logic found;
        found = 1'b0;
        idx = start;
        for (int i = 0; i < num_idx; i++) begin
            if (!found && exp_left[idx] != 0) begin
                idx = idx + 1'b1;
            end else begin
                found = 1'b1;
            end
        end
    endtask

    task automatic send_op(input mem_kind_e kind, input store_size_e size,
                           input logic [31:0] base, input logic [11:0] imm);
        stamofu_issue_t op;
        stamofu_req_t   b0;
        stamofu_req_t   b1;
        logic [31:0]    v;
        int             n;
        logic [`CQ_INDEX_WIDTH-1:0] idx;
        rand_bits(stim_lfsr, 32, v);
        op.data = v;
        rand_bits(stim_lfsr, 4, v);
        op.amo_op = v[3:0];
        rand_bits(stim_lfsr, `CQ_INDEX_WIDTH, v);
        pick_index(v[`CQ_INDEX_WIDTH-1:0], idx);
        op.kind = kind;
        op.size = size;
        op.imm12 = imm;
        op.base = base;
        op.cq_index = idx;
        n = ref_beats(op, b0, b1);
        issue = op;
        issue_valid = 1'b1;
        @(negedge CLK);
        while (!issue_ready) begin
            @(negedge CLK);
        end
        exp_beat[idx][0] = b0;
        exp_beat[idx][1] = b1;
        exp_head[idx] = 0;
        exp_left[idx] = n;
        @(posedge CLK);
        #10;
        issue_valid = 1'b0;
    endtask

    // random base and imm12 with the address offset forced
    task automatic send_at(input mem_kind_e kind, input store_size_e size,
                           input logic [1:0] off);
        logic [31:0] base;
        logic [31:0] imm;
        rand_bits(stim_lfsr, 32, base);
        rand_bits(stim_lfsr, 12, imm);
        send_op(kind, size, {base[31:2], off}, {imm[11:2], 2'b00});
    endtask

    task automatic wait_drain();
        int left;
        do begin
            @(negedge CLK);
            left = 0;
            for (int i = 0; i < num_idx; i++) begin
                left += exp_left[i];
            end
        end while (left != 0);
        @(posedge CLK);
        #10;
    endtask

    task automatic end_test(input string name, input int errs_before);
        wait_drain();
        if (err_count == errs_before) begin
            pass_count++;
            $display("%s: passed", name);
        end else begin
            fail_count++;
            $display("%s: failed with %0d errors", name, err_count - errs_before);
        end
    endtask

    // ------------------------------------------------------------
    // test sequence
    // ------------------------------------------------------------

    initial begin : stimulus
        int          errs;
        logic [31:0] v;
        logic [31:0] base;
        logic [31:0] imm;
        mem_kind_e   kind;
        store_size_e size;
        issue_valid = 1'b0;
        issue = '0;
        req_ack = 1'b0;
        ack_random = 1'b0;
        stim_lfsr = 16'd69;
        ack_lfsr = 16'd69;
        err_count = 0;
        pass_count = 0;
        fail_count = 0;
        for (int i = 0; i < num_idx; i++) begin
            exp_head[i] = 0;
            exp_left[i] = 0;
        end
        @(posedge nRST);
        @(negedge CLK);
        compare_bit("req_valid", 1'b0, req_valid);
        compare_bit("issue_ready", 1'b1, issue_ready);
        @(posedge CLK);
        #10;

        errs = err_count;
        for (int off = 0; off < 4; off++) begin
            send_at(KIND_STORE, SIZE_B, 2'(off));
        end
        for (int off = 0; off < 3; off++) begin
            send_at(KIND_STORE, SIZE_H, 2'(off));
        end
        send_at(KIND_STORE, SIZE_W, 2'd0);
        end_test("aligned stores", errs);

        // back to back so the other lane holds a request during the split
        errs = err_count;
        for (int rep = 0; rep < 2; rep++) begin
            ack_random = (rep == 1);
            for (int off = 1; off < 4; off++) begin
                send_at(KIND_STORE, SIZE_W, 2'(off));
            end
            send_at(KIND_STORE, SIZE_H, 2'd3);
        end
        end_test("split stores", errs);
        ack_random = 1'b0;

        errs = err_count;
        for (int off = 0; off < 4; off++) begin
            send_at(KIND_AMO, SIZE_W, 2'(off));
        end
        end_test("amo", errs);

        // offsets that would split a store of the same size
        errs = err_count;
        send_at(KIND_FENCE, SIZE_W, 2'd1);
        send_at(KIND_FENCE, SIZE_H, 2'd3);
        end_test("fence", errs);

        errs = err_count;
        ack_random = 1'b1;
        for (int n = 0; n < 60; n++) begin
            rand_bits(stim_lfsr, 2, v);
            kind = (v[1:0] == 2'd3) ? KIND_STORE : mem_kind_e'(v[1:0]);
            rand_bits(stim_lfsr, 2, v);
            size = (v[1:0] == 2'd3) ? SIZE_W : store_size_e'(v[1:0]);
            rand_bits(stim_lfsr, 32, base);
            rand_bits(stim_lfsr, 12, imm);
            send_op(kind, size, base, imm[11:0]);
            rand_bits(stim_lfsr, 3, v);
            if (v[2]) begin
                repeat (int'(v[1:0]) + 1) @(posedge CLK);
                #10;
            end
        end
        end_test("random mix", errs);
        ack_random = 1'b0;

        $display("tests passed %0d, failed %0d", pass_count, fail_count);
        if (fail_count == 0 && err_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verif/stamofu_clk_gen.sv */
// testbench clock and reset

`timescale 1ns/10ps
`default_nettype none

module stamofu_clk_gen #(
    parameter int half_period = 50,
    parameter int reset_cycles = 8
) (
    output logic CLK,
    output logic nRST
);

    initial begin
        CLK = 1'b0;
        forever #(half_period) CLK = ~CLK;
    end

    // release just after an edge so the first active edge is clean
    initial begin
        nRST = 1'b0;
        repeat (reset_cycles) @(posedge CLK);
        #10;
        nRST = 1'b1;
    end

endmodule

`default_nettype wire

/* design/stamofu_addr_top.sv */
// store address unit top

`timescale 1ns/10ps
`default_nettype none

`include "stamofu_consts.svh"

module stamofu_addr_top #(
    parameter int lane_count = `STAMOFU_LANES
) (
    input  wire                        CLK,
    input  wire                        nRST,
    input  wire                        issue_valid,
    input  wire stamofu_pkg::stamofu_issue_t issue,
    output logic                       issue_ready,
    output logic                       req_valid,
    output stamofu_pkg::stamofu_req_t  req,
    input  wire                        req_ack
);

    import stamofu_pkg::*;

    logic [lane_count-1:0] lane_issue_valid;
    logic [lane_count-1:0] lane_room;
    logic [lane_count-1:0] lane_req_valid;
    logic [lane_count-1:0] lane_req_ack;
    stamofu_req_t          lane_req [lane_count];

    stamofu_issue_steer #(
        .lane_count(lane_count)
    ) stamofu_issue_steer_i (
        .CLK(CLK),
        .nRST(nRST),
        .issue_valid(issue_valid),
        .issue_ready(issue_ready),
        .lane_room(lane_room),
        .lane_issue_valid(lane_issue_valid)
    );

    // issue record is shared, each lane gets its own valid
    for (genvar i = 0; i < lane_count; i++) begin : g_lane
        stamofu_addr_lane stamofu_addr_lane_i (
            .CLK(CLK),
            .nRST(nRST),
            .issue_valid(lane_issue_valid[i]),
            .issue(issue),
            .room(lane_room[i]),
            .req_valid(lane_req_valid[i]),
            .req(lane_req[i]),
            .req_ack(lane_req_ack[i])
        );
    end

    stamofu_req_arb #(
        .lane_count(lane_count)
    ) stamofu_req_arb_i (
        .CLK(CLK),
        .nRST(nRST),
        .lane_req_valid(lane_req_valid),
        .lane_req(lane_req),
        .lane_req_ack(lane_req_ack),
        .req_valid(req_valid),
        .req(req),
        .req_ack(req_ack)
    );

endmodule

`default_nettype wire

/* design/stamofu_req_arb.sv */
// request arbiter

`timescale 1ns/10ps
`default_nettype none

module stamofu_req_arb #(
    parameter int lane_count = 2
) (
    input  wire                        CLK,
    input  wire                        nRST,
    input  wire  [lane_count-1:0]      lane_req_valid,
    input  wire stamofu_pkg::stamofu_req_t lane_req [lane_count],
    output logic [lane_count-1:0]      lane_req_ack,
    output logic                       req_valid,
    output stamofu_pkg::stamofu_req_t  req,
    input  wire                        req_ack
);

    localparam int idx_w = (lane_count > 1) ? $clog2(lane_count) : 1;

    logic [idx_w-1:0] last_idx;
    logic [idx_w-1:0] grant_idx;
    logic [idx_w-1:0] pick;
    logic [idx_w-1:0] cur;
    // beat waiting on ack
    logic             hold;
    // split store, second beat pending
    logic             locked;
    int               cand;

    // ---------------------------------------------------------
    // round robin after the last granted lane
    // ---------------------------------------------------------

    always_comb begin
        pick = last_idx;
        for (int i = lane_count; i >= 1; i--) begin
            cand = int'(last_idx) + i;
            if (cand >= lane_count) begin
                cand = cand - lane_count;
            end
            if (lane_req_valid[cand]) begin
                pick = idx_w'(cand);
            end
        end
    end

    assign cur = (hold | locked) ? grant_idx : pick;
    assign req_valid = lane_req_valid[cur];
    assign req = lane_req[cur];
    assign lane_req_ack = (req_valid & req_ack) ? (lane_count'(1) << cur) : '0;

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            hold <= 1'b0;
            locked <= 1'b0;
            grant_idx <= '0;
            last_idx <= idx_w'(lane_count - 1);
        end else if (req_valid) begin
            grant_idx <= cur;
            if (req_ack) begin
                hold <= 1'b0;
                last_idx <= cur;
                locked <= req.misaligned & ~req.is_mq;
            end else begin
                hold <= 1'b1;
            end
        end
    end

    a_arb_lock_mq: assert property (@(posedge CLK) disable iff (!nRST)
        locked |-> req_valid && req.is_mq);

endmodule

`default_nettype wire

/* design/stamofu_addr_lane.sv */
// store address lane

`timescale 1ns/10ps
`default_nettype none

`include "stamofu_consts.svh"

module stamofu_addr_lane (
    input  wire                        CLK,
    input  wire                        nRST,
    input  wire                        issue_valid,
    input  wire stamofu_pkg::stamofu_issue_t issue,
    output logic                       room,
    output logic                       req_valid,
    output stamofu_pkg::stamofu_req_t  req,
    input  wire                        req_ack
);

    import stamofu_pkg::*;

    // hold stage
    logic           hold_valid;
    stamofu_issue_t hold_issue;
    logic [31:0]    hold_va;

    // request stage
    req_state_e     state;
    req_state_e     next_state;
    stamofu_issue_t stage_op;
    logic [31:0]    stage_va;
    logic [31:0]    stage_va_mq;
    logic [31:0]    beat_va;
    logic [1:0]     offset;
    logic           stall;
    logic           advance;
    logic           misaligned;
    logic           misaligned_exception;
    logic [3:0]     first_mask;
    logic [3:0]     second_mask;
    logic [31:0]    write_data;

    assign advance = hold_valid & ~stall;
    assign room = ~hold_valid | ~stall;

    // ---------------------------------------------------------
    // hold stage
    // ---------------------------------------------------------

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            hold_valid <= 1'b0;
        end else begin
            hold_valid <= issue_valid | (hold_valid & stall);
        end
    end

    always_ff @(posedge CLK) begin
        if (issue_valid) begin
            hold_issue <= issue;
        end
    end

    // AMOs address off the base alone
    always_comb begin
        if (hold_issue.kind == KIND_AMO) begin
            hold_va = hold_issue.base;
        end else begin
            hold_va = hold_issue.base + {{20{hold_issue.imm12[11]}}, hold_issue.imm12};
        end
    end

    // ---------------------------------------------------------
    // request stage
    // ---------------------------------------------------------

    always_ff @(posedge CLK) begin
        if (advance) begin
            stage_op <= hold_issue;
            stage_va <= hold_va;
            stage_va_mq <= hold_va + 32'd4;
        end
    end

    assign offset = stage_va[1:0];
    assign beat_va = (state == REQ_MISALIGNED) ? stage_va_mq : stage_va;
    assign misaligned_exception = (stage_op.kind == KIND_AMO) && (offset != 2'd0);

    always_comb begin
        // word mask is the default for AMO and fence
        case (offset)
            2'd0: first_mask = 4'b1111;
            2'd1: first_mask = 4'b1110;
            2'd2: first_mask = 4'b1100;
            default: first_mask = 4'b1000;
        endcase
        second_mask = 4'b0000;
        misaligned = 1'b0;
        if (stage_op.kind == KIND_STORE) begin
            case (stage_op.size)
                SIZE_B: begin
                    first_mask = 4'b0001 << offset;
                end
                SIZE_H: begin
                    // only offset 3 crosses the word
                    misaligned = (offset == 2'd3);
                    second_mask = 4'b0001;
                    case (offset)
                        2'd0: first_mask = 4'b0011;
                        2'd1: first_mask = 4'b0110;
                        2'd2: first_mask = 4'b1100;
                        default: first_mask = 4'b1000;
                    endcase
                end
                default: begin
                    misaligned = (offset != 2'd0);
                    case (offset)
                        2'd1: second_mask = 4'b0001;
                        2'd2: second_mask = 4'b0011;
                        2'd3: second_mask = 4'b0111;
                        default: second_mask = 4'b0000;
                    endcase
                end
            endcase
        end
    end

    // rotate left one byte per byte of offset
    always_comb begin
        case (offset)
            2'd0: write_data = stage_op.data;
            2'd1: write_data = {stage_op.data[23:0], stage_op.data[31:24]};
            2'd2: write_data = {stage_op.data[15:0], stage_op.data[31:16]};
            default: write_data = {stage_op.data[7:0], stage_op.data[31:8]};
        endcase
    end

    // ---------------------------------------------------------
    // request state machine
    // ---------------------------------------------------------

    always_comb begin
        stall = 1'b0;
        next_state = state;
        case (state)
            REQ_IDLE: begin
                next_state = hold_valid ? REQ_ACTIVE : REQ_IDLE;
            end
            REQ_ACTIVE: begin
                if (req_ack && misaligned) begin
                    // keep the op for the second word
                    stall = 1'b1;
                    next_state = REQ_MISALIGNED;
                end else if (req_ack) begin
                    next_state = hold_valid ? REQ_ACTIVE : REQ_IDLE;
                end else begin
                    stall = 1'b1;
                end
            end
            REQ_MISALIGNED: begin
                if (req_ack) begin
                    next_state = hold_valid ? REQ_ACTIVE : REQ_IDLE;
                end else begin
                    stall = 1'b1;
                end
            end
            default: begin
                next_state = REQ_IDLE;
            end
        endcase
    end

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            state <= REQ_IDLE;
        end else begin
            state <= next_state;
        end
    end

    assign req_valid = (state != REQ_IDLE);

    always_comb begin
        req.kind = stage_op.kind;
        req.size = stage_op.size;
        req.amo_op = stage_op.amo_op;
        req.is_mq = (state == REQ_MISALIGNED);
        req.misaligned = misaligned;
        req.misaligned_exception = misaligned_exception;
        req.vpn = beat_va[31 -: `VPN_WIDTH];
        req.po_word = beat_va[`PO_WIDTH-1:2];
        req.byte_mask = (state == REQ_MISALIGNED) ? second_mask : first_mask;
        req.write_data = write_data;
        req.cq_index = stage_op.cq_index;
    end

    a_lane_req_stable: assert property (@(posedge CLK) disable iff (!nRST)
        req_valid && !req_ack |=> req_valid && $stable(req));

    // a new op only lands on a free or moving hold stage
    a_lane_hold_free: assert property (@(posedge CLK) disable iff (!nRST)
        issue_valid |-> room);

endmodule

`default_nettype wire

/* design/stamofu_issue_steer.sv */
// issue steering

`timescale 1ns/10ps
`default_nettype none

module stamofu_issue_steer #(
    parameter int lane_count = 2
) (
    input  wire                   CLK,
    input  wire                   nRST,
    input  wire                   issue_valid,
    output logic                  issue_ready,
    input  wire  [lane_count-1:0] lane_room,
    output logic [lane_count-1:0] lane_issue_valid
);

    localparam int idx_w = (lane_count > 1) ? $clog2(lane_count) : 1;

    logic [idx_w-1:0] ptr;
    logic [idx_w-1:0] sel;
    logic             accept;
    int               cand;

    // ---------------------------------------------------------
    // lane select
    // ---------------------------------------------------------

    // scan downward so the lane nearest the pointer wins
    always_comb begin
        sel = ptr;
        for (int i = lane_count - 1; i >= 0; i--) begin
            cand = int'(ptr) + i;
            if (cand >= lane_count) begin
                cand = cand - lane_count;
            end
            if (lane_room[cand]) begin
                sel = idx_w'(cand);
            end
        end
    end

    assign issue_ready = |lane_room;
    assign accept = issue_valid & issue_ready;
    assign lane_issue_valid = accept ? (lane_count'(1) << sel) : '0;

    // pointer moves past the lane that just took an op
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            ptr <= '0;
        end else if (accept) begin
            ptr <= (sel == idx_w'(lane_count - 1)) ? '0 : sel + 1'b1;
        end
    end

    // an issue only goes to a lane that reported room
    a_steer_room: assert property (@(posedge CLK) disable iff (!nRST)
        (lane_issue_valid & ~lane_room) == '0);

endmodule

`default_nettype wire

/* design/stamofu_pkg.sv */
// store address unit types

`default_nettype none

`include "stamofu_consts.svh"

package stamofu_pkg;

    typedef enum logic [1:0] {
        KIND_STORE,
        KIND_AMO,
        KIND_FENCE
    } mem_kind_e;

    // only meaningful for stores
    typedef enum logic [1:0] {
        SIZE_B,
        SIZE_H,
        SIZE_W
    } store_size_e;

    typedef enum logic [1:0] {
        REQ_IDLE,
        REQ_ACTIVE,
        REQ_MISALIGNED
    } req_state_e;

    // ---------------------------------------------------------
    // issue record and request beat
    // ---------------------------------------------------------

    typedef struct packed {
        mem_kind_e                  kind;
        store_size_e                size;
        logic [3:0]                 amo_op;
        logic [11:0]                imm12;
        logic [31:0]                base;
        logic [31:0]                data;
        logic [`CQ_INDEX_WIDTH-1:0] cq_index;
    } stamofu_issue_t;

    typedef struct packed {
        mem_kind_e                  kind;
        store_size_e                size;
        logic [3:0]                 amo_op;
        // second beat of a split store
        logic                       is_mq;
        logic                       misaligned;
        logic                       misaligned_exception;
        logic [`VPN_WIDTH-1:0]      vpn;
        logic [`PO_WIDTH-3:0]       po_word;
        logic [3:0]                 byte_mask;
        logic [31:0]                write_data;
        logic [`CQ_INDEX_WIDTH-1:0] cq_index;
    } stamofu_req_t;

endpackage

`default_nettype wire

/* design/stamofu_consts.svh */
// store address unit constants

`ifndef STAMOFU_CONSTS_SVH
`define STAMOFU_CONSTS_SVH

// ---------------------------------------------------------
// lane count
// ---------------------------------------------------------

// default number of address lanes at the top level
`define STAMOFU_LANES 2

// ---------------------------------------------------------
// address and index widths
// ---------------------------------------------------------

`define VPN_WIDTH 20
// word offset is the page offset minus the byte bits
`define PO_WIDTH 12
`define CQ_INDEX_WIDTH 4

`endif
